//--- files.f
+incdir+hdl
hdl/fpu_mul_pkg.sv
hdl/fpu_mul_lzc.sv
hdl/fpu_mul_prenorm.sv
hdl/fpu_mul_expalign.sv
hdl/fpu_mul_core.sv
hdl/fpu_mul_top.sv
verif/fpu_mul_clkgen.sv
verif/fpu_mul_assert.sv
verif/fpu_mul_tb.sv

//--- verif/fpu_mul_tb.sv
// single clock; results are compared only when rdy_o rises on an advancing edge, in order
`include "fpu_mul_settings.svh"

module fpu_mul_tb
  import fpu_mul_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int clk_period_ns  = 20;
  localparam int drive_delay_ns = 2;
  localparam int n_random       = 64;
  localparam int n_zero_inf     = 24;
  localparam int n_nan          = 16;
  localparam int n_denorm       = 32;
  localparam int n_stall        = 40;
  // directed ops in tests 2, 4 and 5
  localparam int n_total        = n_random + n_zero_inf + n_nan + n_denorm + n_stall + 22;
  // up to four cycles per op with stalls, plus drains and flush gaps
  localparam int timeout_ns     = (n_total * 6 + 200) * clk_period_ns;
  localparam fpu_nan_t no_nan   = '0;

  logic         clk;
  logic         rst;
  logic         start;
  logic         adv;
  logic         flush;
  fpu_operand_t opa;
  fpu_operand_t opb;
  fpu_nan_t     nan;
  fpu_mul_res_t res;
  logic         rdy;

  // expected results in issue order
  fpu_mul_res_t exp_q[$];
  int           id_q[$];
  int           edge_q[$];
  logic         zero_q[$];
  integer       seed      = 32'hdb85bf26;
  int           cur_test  = 0;
  int           adv_edges = 0;
  logic         last_adv  = 1'b0;

  fpu_mul_clkgen clkgen_inst (
    .clk_o (clk),
    .rst_o (rst)
  );

  fpu_mul_top fpu_mul_top_inst (
    .clk     (clk),
    .rst     (rst),
    .flush_i (flush),
    .adv_i   (adv),
    .start_i (start),
    .opa_i   (opa),
    .opb_i   (opb),
    .nan_i   (nan),
    .res_o   (res),
    .rdy_o   (rdy)
  );

  //////////////////////////////////////////////////////////////////////
  // reporting
  //////////////////////////////////////////////////////////////////////

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("ERRORS FOUND");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_value(input string test, input string what,
                             input logic [63:0] expected, input logic [63:0] actual);
    if (actual !== expected) begin
      fail_run($sformatf("[ERROR] %s: %s expected %0h actual %0h",
                         test, what, expected, actual));
    end
  endtask

  function automatic string test_name(input int id);
    case (id)
      1:       return "random_normal";
      2:       return "zero_inf";
      3:       return "nan_pass";
      4:       return "denormal_shift";
      5:       return "stall_flush";
      default: return "unknown";
    endcase
  endfunction

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  // msb-first count, zero fraction reports 0
  function automatic int lead_zeros(input logic [`FPU_FRACT_W-1:0] f);
    int n;
    n = 0;
    if (f == '0) begin
      return 0;
    end
    while (!f[`FPU_FRACT_W-1-n]) begin
      n++;
    end
    return n;
  endfunction

  function automatic fpu_mul_res_t fpu_mul_ref(input fpu_operand_t a, input fpu_operand_t b,
                                               input fpu_nan_t n);
    fpu_mul_res_t          r;
    logic                  zp;
    int                    nlza;
    int                    nlzb;
    int                    shift;
    logic [`FPU_EXP_W-1:0] exp_c;
    logic [`FPU_EXP_W-1:0] exp_r;
    logic [63:0]           ma;
    logic [63:0]           mb;
    logic [63:0]           prod;
    zp   = a.zero | b.zero;
    nlza = lead_zeros(a.fract24);
    nlzb = lead_zeros(b.fract24);
    // normalized fractions, each followed by eight zeros
    ma   = '0;
    mb   = '0;
    if (!zp) begin
      ma[31:8] = a.fract24 << nlza;
      mb[31:8] = b.fract24 << nlzb;
    end
    prod = ma * mb;
    exp_c = zp ? '0 : `FPU_EXP_W'(int'(a.exp10) + int'(b.exp10) - nlza - nlzb - `FPU_BIAS);
    if (zp) begin
      shift = 0;
      exp_r = '0;
    end else if (exp_c[`FPU_EXP_W-1]) begin
      // negative sum
      shift = 1025 - int'(exp_c);
      exp_r = `FPU_EXP_W'(1);
    end else if (exp_c == '0) begin
      shift = 1;
      exp_r = `FPU_EXP_W'(1);
    end else begin
      shift = 0;
      exp_r = exp_c;
    end
    if (shift > 31) begin
      shift = 31;
    end
    r.sign      = a.sign ^ b.sign;
    r.shr       = `FPU_SHR_W'(shift);
    r.exp10shr  = exp_r;
    r.exp10sh0  = exp_c;
    r.fract28   = {prod[63:37], |prod[36:0]};
    r.inv       = (a.zero & b.inf) | (b.zero & a.inf);
    r.inf       = a.inf | b.inf;
    r.snan      = n.snan;
    r.qnan      = n.qnan;
    r.anan_sign = n.anan_sign;
    return r;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // operand generators
  //////////////////////////////////////////////////////////////////////

  function automatic int rand_below(input int n);
    logic [31:0] r;
    r = $random(seed);
    return int'(r % n);
  endfunction

  // biased exponent 1..254, hidden bit set
  function automatic fpu_operand_t rand_normal();
    fpu_operand_t op;
    logic [31:0]  r;
    r          = $random(seed);
    op.sign    = r[31];
    op.exp10   = `FPU_EXP_W'(1 + (r[30:23] % 8'd254));
    op.fract24 = {1'b1, r[22:0]};
    op.inf     = 1'b0;
    op.zero    = 1'b0;
    return op;
  endfunction

  function automatic fpu_operand_t set_exp(input fpu_operand_t op, input int e);
    fpu_operand_t o;
    o       = op;
    o.exp10 = `FPU_EXP_W'(e);
    return o;
  endfunction

  function automatic fpu_operand_t make_zero(input logic sign);
    fpu_operand_t op;
    op      = '0;
    op.sign = sign;
    op.zero = 1'b1;
    return op;
  endfunction

  function automatic fpu_operand_t make_inf(input logic sign);
    fpu_operand_t op;
    op         = '0;
    op.sign    = sign;
    op.exp10   = `FPU_EXP_W'(255);
    op.fract24 = 24'h800000;
    op.inf     = 1'b1;
    return op;
  endfunction

  // one in four zero, one in four infinite
  function automatic fpu_operand_t rand_special();
    fpu_operand_t op;
    logic [31:0]  r;
    op = rand_normal();
    r  = $random(seed);
    case (r[1:0])
      2'd0:    op = make_zero(r[2]);
      2'd1:    op = make_inf(r[2]);
      default: op = op;
    endcase
    return op;
  endfunction

  // 1 to 23 leading zeros
  function automatic fpu_operand_t rand_denorm(input int e);
    fpu_operand_t op;
    logic [31:0]  r;
    op         = set_exp(rand_normal(), e);
    r          = $random(seed);
    op.fract24 = op.fract24 >> (1 + (r[4:0] % 5'd23));
    return op;
  endfunction

  function automatic fpu_nan_t rand_nan();
    logic [31:0] r;
    r = $random(seed);
    return r[2:0];
  endfunction

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  task automatic drive(input logic st, input logic ad, input logic fl,
                       input fpu_operand_t a, input fpu_operand_t b, input fpu_nan_t n);
    @(posedge clk);
    #(drive_delay_ns);
    start = st;
    adv   = ad;
    flush = fl;
    opa   = a;
    opb   = b;
    nan   = n;
  endtask

  task automatic issue(input fpu_operand_t a, input fpu_operand_t b, input fpu_nan_t n);
    drive(1'b1, 1'b1, 1'b0, a, b, n);
  endtask

  task automatic idle();
    drive(1'b0, 1'b1, 1'b0, opa, opb, nan);
  endtask

  task automatic wait_drained(input int max_cycles);
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < max_cycles) begin
      idle();
      n++;
    end
    if (exp_q.size() != 0) begin
      fail_run($sformatf("%0d results still pending after %0d idle cycles",
                         exp_q.size(), max_cycles));
    end
  endtask

  // accept side, inputs are stable at the edge
  always @(posedge clk) begin
    if (!rst) begin
      if (adv) begin
        adv_edges++;
      end
      last_adv = adv && !flush;
      if (flush) begin
        // in-flight ops never report
        exp_q.delete();
        id_q.delete();
        edge_q.delete();
        zero_q.delete();
      end else if (adv && start) begin
        exp_q.push_back(fpu_mul_ref(opa, opb, nan));
        id_q.push_back(cur_test);
        edge_q.push_back(adv_edges);
        zero_q.push_back(opa.zero | opb.zero);
      end
    end
  end

  // compare side, outputs settled by the falling edge
  always @(negedge clk) begin
    fpu_mul_res_t e;
    string        name;
    int           acc;
    logic         zero_op;
    if (!rst && rdy && last_adv) begin
      if (exp_q.size() == 0) begin
        fail_run("rdy_o rose with no operation in flight");
      end else begin
        e       = exp_q.pop_front();
        name    = test_name(id_q.pop_front());
        acc     = edge_q.pop_front();
        zero_op = zero_q.pop_front();
        // accepting edge counts as the first
        check_value(name, "latency", 64'(`FPU_MUL_LATENCY), 64'(adv_edges - acc + 1));
        check_value(name, "sign", 64'(e.sign), 64'(res.sign));
        check_value(name, "shr", 64'(e.shr), 64'(res.shr));
        check_value(name, "exp10shr", 64'(e.exp10shr), 64'(res.exp10shr));
        check_value(name, "exp10sh0", 64'(e.exp10sh0), 64'(res.exp10sh0));
        check_value(name, "fract28", 64'(e.fract28), 64'(res.fract28));
        check_value(name, "inv", 64'(e.inv), 64'(res.inv));
        check_value(name, "inf", 64'(e.inf), 64'(res.inf));
        check_value(name, "snan", 64'(e.snan), 64'(res.snan));
        check_value(name, "qnan", 64'(e.qnan), 64'(res.qnan));
        check_value(name, "anan_sign", 64'(e.anan_sign), 64'(res.anan_sign));
        if (zero_op) begin
          // any zero operand clears exponent, shift and fraction
          check_value(name, "zero exp10sh0", 64'(0), 64'(res.exp10sh0));
          check_value(name, "zero shr", 64'(0), 64'(res.shr));
          check_value(name, "zero fract28", 64'(0), 64'(res.fract28));
        end
      end
    end
  end

  always @(negedge clk) begin
    if (fpu_mul_top_inst.fpu_mul_assert_inst.fail_count != 0) begin
      fail_run("a concurrent assertion on the ready or stall protocol failed");
    end
  end

  initial begin
    #(timeout_ns);
    fail_run($sformatf("watchdog expired after %0d ns, run did not finish", timeout_ns));
  end

  initial begin
    start = 1'b0;
    adv   = 1'b1;
    flush = 1'b0;
    opa   = '0;
    opb   = '0;
    nan   = '0;
    wait (rst === 1'b1);
    @(negedge rst);

    // back to back normals
    cur_test = 1;
    for (int i = 0; i < n_random; i++) begin
      issue(rand_normal(), rand_normal(), no_nan);
    end
    wait_drained(20);

    // zero and infinity mixes
    cur_test = 2;
    issue(make_zero(1'b0), make_inf(1'b1), no_nan);
    issue(make_inf(1'b0), make_zero(1'b0), no_nan);
    issue(make_inf(1'b1), make_inf(1'b1), no_nan);
    issue(make_zero(1'b1), make_zero(1'b0), no_nan);
    issue(make_zero(1'b0), rand_normal(), no_nan);
    issue(rand_normal(), make_inf(1'b0), no_nan);
    for (int i = 0; i < n_zero_inf; i++) begin
      issue(rand_special(), rand_special(), no_nan);
    end
    wait_drained(20);

    // nan info rides along unchanged
    cur_test = 3;
    for (int i = 0; i < n_nan; i++) begin
      issue(rand_special(), rand_special(), rand_nan());
    end
    wait_drained(20);

    // sums of zero, slightly negative, at and past saturation
    cur_test = 4;
    issue(set_exp(rand_normal(), 63), set_exp(rand_normal(), 64), no_nan);
    issue(set_exp(rand_normal(), 60), set_exp(rand_normal(), 60), no_nan);
    issue(set_exp(rand_normal(), 50), set_exp(rand_normal(), 50), no_nan);
    issue(set_exp(rand_normal(), 48), set_exp(rand_normal(), 48), no_nan);
    issue(set_exp(rand_normal(), 64), set_exp(rand_normal(), 64), no_nan);
    issue(rand_denorm(1), rand_denorm(1), no_nan);
    issue(rand_denorm(1), set_exp(rand_normal(), 200), no_nan);
    for (int i = 0; i < n_denorm; i++) begin
      issue(rand_denorm(rand_below(64)), set_exp(rand_normal(), 32 + rand_below(96)), no_nan);
    end
    wait_drained(20);

    // random stalls with ops in flight
    cur_test = 5;
    for (int i = 0; i < n_stall; i++) begin
      repeat (rand_below(4)) begin
        drive(rand_below(2) == 1, 1'b0, 1'b0, rand_normal(), rand_normal(), no_nan);
      end
      issue(rand_special(), rand_normal(), no_nan);
    end
    wait_drained(20);

    // flush while advancing
    issue(rand_normal(), rand_normal(), no_nan);
    issue(rand_normal(), rand_normal(), no_nan);
    issue(rand_normal(), rand_normal(), no_nan);
    drive(1'b0, 1'b1, 1'b1, opa, opb, nan);
    repeat (8) idle();

    // flush during a stall
    issue(rand_normal(), rand_normal(), no_nan);
    issue(rand_normal(), rand_normal(), no_nan);
    drive(1'b0, 1'b0, 1'b0, opa, opb, nan);
    drive(1'b0, 1'b0, 1'b1, opa, opb, nan);
    repeat (8) idle();

    // pipe recovers after flush
    for (int i = 0; i < 4; i++) begin
      issue(rand_normal(), rand_normal(), no_nan);
    end
    wait_drained(20);

    if (exp_q.size() != 0 || fpu_mul_top_inst.fpu_mul_assert_inst.fail_count != 0) begin
      fail_run("results pending or assertions failed at end of run");
    end else begin
      $display("NO ERRORS");
      $finish;
    end
  end

endmodule

//--- verif/fpu_mul_assert.sv
// protocol checks on the ready chain and stalls only; data values are not looked at here
`include "fpu_mul_settings.svh"

module fpu_mul_assert
  import fpu_mul_pkg::*;
(
  input logic         clk,
  input logic         rst,
  input logic         flush_i,
  input logic         adv_i,
  input logic         start_i,
  input fpu_mul_res_t res_i,
  input logic         rdy_i
);
  timeunit 1ns;
  timeprecision 100ps;

  // failed assertion count
  int fail_count = 0;

  // accepted ops by advancing edges seen, msb is one edge short of ready
  logic [`FPU_MUL_LATENCY-2:0] pend;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pend <= '0;
    end else if (flush_i) begin
      pend <= '0;
    end else if (adv_i) begin
      pend <= {pend[`FPU_MUL_LATENCY-3:0], start_i};
    end
  end

  //////////////////////////////////////////////////////////////////////
  // ready and flush protocol
  //////////////////////////////////////////////////////////////////////

  rdy_low_in_reset: assert property (@(posedge clk) rst |-> !rdy_i)
    else begin
      fail_count++;
      $error("rdy_o high while reset is asserted");
    end

  // last advancing edge of the latency window raises ready
  rdy_after_latency: assert property (@(posedge clk) disable iff (rst)
    (adv_i && !flush_i && pend[`FPU_MUL_LATENCY-2]) |=> rdy_i)
    else begin
      fail_count++;
      $error("rdy_o missing after an accepted start");
    end

  rdy_low_after_flush: assert property (@(posedge clk) disable iff (rst) flush_i |=> !rdy_i)
    else begin
      fail_count++;
      $error("rdy_o high on the edge after a flush");
    end

  // full stall, output register frozen
  res_hold_on_stall: assert property (@(posedge clk) disable iff (rst)
    !adv_i |=> $stable(res_i))
    else begin
      fail_count++;
      $error("res_o changed on a non-advancing edge");
    end

endmodule

bind fpu_mul_top fpu_mul_assert fpu_mul_assert_inst (
  .clk     (clk),
  .rst     (rst),
  .flush_i (flush_i),
  .adv_i   (adv_i),
  .start_i (start_i),
  .res_i   (res_o),
  .rdy_i   (rdy_o)
);

//--- verif/fpu_mul_clkgen.sv
// free-running 20 ns clock; reset rises at 1 ns and drops 2 ns after the third rising edge
module fpu_mul_clkgen (
  output logic clk_o,
  output logic rst_o
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int period_ns    = 20;
  localparam int reset_cycles = 3;

  initial begin
    clk_o = 1'b0;
    forever #(period_ns / 2) clk_o = ~clk_o;
  end

  // clean rising edge on rst for the async reset flops
  initial begin
    rst_o = 1'b0;
    #1;
    rst_o = 1'b1;
    repeat (reset_cycles) @(posedge clk_o);
    #2;
    rst_o = 1'b0;
  end

endmodule

//--- hdl/fpu_mul_top.sv
// adv_i low stalls the whole pipe; flush_i drops in-flight results but keeps data registers
`include "fpu_mul_settings.svh"

module fpu_mul_top
  import fpu_mul_pkg::*;
(
  input  logic         clk,
  input  logic         rst,
  input  logic         flush_i,
  input  logic         adv_i,
  input  logic         start_i,
  input  fpu_operand_t opa_i,
  input  fpu_operand_t opb_i,
  input  fpu_nan_t     nan_i,
  output fpu_mul_res_t res_o,
  output logic         rdy_o
);

  // stage 0 to stage 1
  fpu_prenorm_t            s0;
  logic                    s0_rdy;
  // normalized fractions into the multiplier
  logic [`FPU_FRACT_W-1:0] fa;
  logic [`FPU_FRACT_W-1:0] fb;
  logic                    mul_go;
  // stage 2 beside the partial products
  fpu_align_t              s2;
  logic                    s2_rdy;

  //////////////////////////////////////////////////////////////////////
  // pipeline stages
  //////////////////////////////////////////////////////////////////////

  fpu_mul_prenorm prenorm_inst (
    .clk     (clk),
    .rst     (rst),
    .flush_i (flush_i),
    .adv_i   (adv_i),
    .start_i (start_i),
    .opa_i   (opa_i),
    .opb_i   (opb_i),
    .nan_i   (nan_i),
    .s0_o    (s0),
    .rdy_o   (s0_rdy)
  );

  fpu_mul_expalign expalign_inst (
    .clk      (clk),
    .rst      (rst),
    .flush_i  (flush_i),
    .adv_i    (adv_i),
    .s0_i     (s0),
    .s0_rdy_i (s0_rdy),
    .fa_o     (fa),
    .fb_o     (fb),
    .mul_go_o (mul_go),
    .s2_o     (s2),
    .rdy_o    (s2_rdy)
  );

  fpu_mul_core core_inst (
    .clk      (clk),
    .rst      (rst),
    .flush_i  (flush_i),
    .adv_i    (adv_i),
    .fa_i     (fa),
    .fb_i     (fb),
    .mul_go_i (mul_go),
    .s2_i     (s2),
    .s2_rdy_i (s2_rdy),
    .res_o    (res_o),
    .rdy_o    (rdy_o)
  );

endmodule

//--- hdl/fpu_mul_core.sv
// two-stage 32x32 multiply on left-justified fractions; result is unrounded, sticky in bit 0
`include "fpu_mul_settings.svh"

module fpu_mul_core
  import fpu_mul_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    flush_i,
  input  logic                    adv_i,
  input  logic [`FPU_FRACT_W-1:0] fa_i,
  input  logic [`FPU_FRACT_W-1:0] fb_i,
  input  logic                    mul_go_i,
  input  fpu_align_t              s2_i,
  input  logic                    s2_rdy_i,
  output fpu_mul_res_t            res_o,
  output logic                    rdy_o
);

  localparam int part_w = `FPU_PART_W;
  // product bits above the untouched low half of al*bl
  localparam int sum_w  = 3 * part_w;

  // multiplier inputs, [1] high half, [0] low half
  logic [1:0][part_w-1:0] mul_a_q;
  logic [1:0][part_w-1:0] mul_b_q;
  // partial products
  logic [2*part_w-1:0]    pp_ll;
  logic [2*part_w-1:0]    pp_lh;
  logic [2*part_w-1:0]    pp_hl;
  logic [2*part_w-1:0]    pp_hh;
  // product bits 63..16
  logic [sum_w-1:0]       sum48;
  logic                   sticky;

  //////////////////////////////////////////////////////////////////////
  // multiplier input registers
  //////////////////////////////////////////////////////////////////////

  // fraction padded with zeros to 32 bits
  always_ff @(posedge clk) begin
    if (adv_i && mul_go_i) begin
      mul_a_q <= {fa_i, {(2 * part_w - `FPU_FRACT_W){1'b0}}};
      mul_b_q <= {fb_i, {(2 * part_w - `FPU_FRACT_W){1'b0}}};
    end
  end

  // first half: four 16x16 products
  always_ff @(posedge clk) begin
    if (adv_i) begin
      pp_ll <= mul_a_q[0] * mul_b_q[0];
      pp_lh <= mul_a_q[0] * mul_b_q[1];
      pp_hl <= mul_a_q[1] * mul_b_q[0];
      pp_hh <= mul_a_q[1] * mul_b_q[1];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // second half: product sum and output register
  //////////////////////////////////////////////////////////////////////

  // low 16 bits of pp_ll feed only the sticky bit
  assign sum48 = {pp_hh, {part_w{1'b0}}}
               + {{part_w{1'b0}}, pp_lh}
               + {{part_w{1'b0}}, pp_hl}
               + {{(2 * part_w){1'b0}}, pp_ll[2*part_w-1:part_w]};

  // everything below the 27 kept bits
  assign sticky = (|sum48[sum_w-`FPU_RES_FRACT_W:0]) | (|pp_ll[part_w-1:0]);

  always_ff @(posedge clk) begin
    if (adv_i) begin
      res_o.sign      <= s2_i.flags.signc;
      res_o.shr       <= s2_i.shrx;
      res_o.exp10shr  <= s2_i.exp10rx;
      res_o.exp10sh0  <= s2_i.exp10c;
      res_o.fract28   <= {sum48[sum_w-1 -: `FPU_RES_FRACT_W-1], sticky};
      res_o.inv       <= s2_i.flags.inv;
      res_o.inf       <= s2_i.flags.inf;
      res_o.snan      <= s2_i.flags.nan.snan;
      res_o.qnan      <= s2_i.flags.nan.qnan;
      res_o.anan_sign <= s2_i.flags.nan.anan_sign;
    end
  end

  // tail of the ready chain
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rdy_o <= 1'b0;
    end else if (flush_i) begin
      rdy_o <= 1'b0;
    end else if (adv_i) begin
      rdy_o <= s2_rdy_i;
    end
  end

endmodule

//--- hdl/fpu_mul_expalign.sv
// stages 1 and 2; exponent math is modulo 2^10, shift amount saturates at 31
`include "fpu_mul_settings.svh"

module fpu_mul_expalign
  import fpu_mul_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    flush_i,
  input  logic                    adv_i,
  input  fpu_prenorm_t            s0_i,
  input  logic                    s0_rdy_i,
  output logic [`FPU_FRACT_W-1:0] fa_o,
  output logic [`FPU_FRACT_W-1:0] fb_o,
  output logic                    mul_go_o,
  output fpu_align_t              s2_o,
  output logic                    rdy_o
);

  // stage 1 combinational
  logic [`FPU_EXP_W-1:0] exp_sum;
  logic [`FPU_EXP_W-1:0] exp10c;
  // stage 1 registers
  fpu_flags_t            s1_flags;
  logic [`FPU_EXP_W-1:0] s1_exp10c;
  logic                  s1_rdy;
  // stage 2 combinational
  logic                  exp10c_zero;
  logic [`FPU_EXP_W-1:0] shr_neg;
  logic [`FPU_EXP_W-1:0] shr_t;
  logic [`FPU_EXP_W-1:0] exp10rx;
  logic [`FPU_SHR_W-1:0] shrx;

  //////////////////////////////////////////////////////////////////////
  // stage 1: normalize fractions, sum exponents
  //////////////////////////////////////////////////////////////////////

  // left-justify, zeroed for a zero product
  assign fa_o = (s0_i.fract24a << s0_i.nlza) & {`FPU_FRACT_W{~s0_i.flags.opc_0}};
  assign fb_o = (s0_i.fract24b << s0_i.nlzb) & {`FPU_FRACT_W{~s0_i.flags.opc_0}};

  // core loads its multiplier inputs on the same edge
  assign mul_go_o = s0_rdy_i;

  // each exponent corrected by its own shift, bias taken once
  assign exp_sum = s0_i.exp10a - `FPU_EXP_W'(s0_i.nlza)
                 + s0_i.exp10b - `FPU_EXP_W'(s0_i.nlzb)
                 - `FPU_EXP_W'(`FPU_BIAS);
  assign exp10c  = exp_sum & {`FPU_EXP_W{~s0_i.flags.opc_0}};

  always_ff @(posedge clk) begin
    if (adv_i) begin
      s1_flags  <= s0_i.flags;
      s1_exp10c <= exp10c;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      s1_rdy <= 1'b0;
    end else if (flush_i) begin
      s1_rdy <= 1'b0;
    end else if (adv_i) begin
      s1_rdy <= s0_rdy_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stage 2: right shift for negative or denormal results
  //////////////////////////////////////////////////////////////////////

  assign exp10c_zero = ~|s1_exp10c;
  // 1025 minus the sum, same value modulo 2^10
  assign shr_neg     = `FPU_EXP_W'(1) - s1_exp10c;

  always_comb begin
    if (s1_flags.opc_0) begin
      shr_t   = '0;
      exp10rx = '0;
    end else if (s1_exp10c[`FPU_EXP_W-1]) begin
      // negative sum
      shr_t   = shr_neg;
      exp10rx = `FPU_EXP_W'(1);
    end else if (exp10c_zero) begin
      // zero sum, potential denormal
      shr_t   = `FPU_EXP_W'(1);
      exp10rx = `FPU_EXP_W'(1);
    end else begin
      // normal, 1x.xx handled downstream
      shr_t   = '0;
      exp10rx = s1_exp10c;
    end
  end

  // anything above 31 saturates
  assign shrx = shr_t[`FPU_SHR_W-1:0] | {`FPU_SHR_W{|shr_t[`FPU_EXP_W-1:`FPU_SHR_W]}};

  always_ff @(posedge clk) begin
    if (adv_i) begin
      s2_o.flags   <= s1_flags;
      s2_o.exp10c  <= s1_exp10c;
      s2_o.shrx    <= shrx;
      s2_o.exp10rx <= exp10rx;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rdy_o <= 1'b0;
    end else if (flush_i) begin
      rdy_o <= 1'b0;
    end else if (adv_i) begin
      rdy_o <= s1_rdy;
    end
  end

endmodule

//--- hdl/fpu_mul_prenorm.sv
// stage 0; operand nan detection and unpacking are done upstream, only flags are combined here
`include "fpu_mul_settings.svh"

module fpu_mul_prenorm
  import fpu_mul_pkg::*;
(
  input  logic         clk,
  input  logic         rst,
  input  logic         flush_i,
  input  logic         adv_i,
  input  logic         start_i,
  input  fpu_operand_t opa_i,
  input  fpu_operand_t opb_i,
  input  fpu_nan_t     nan_i,
  output fpu_prenorm_t s0_o,
  output logic         rdy_o
);

  // leading zero counts
  logic [`FPU_SHR_W-1:0] nlza;
  logic [`FPU_SHR_W-1:0] nlzb;
  // combined exception flags
  fpu_flags_t            flags;

  //////////////////////////////////////////////////////////////////////
  // exceptions and sign
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    // zero times infinity, either order
    flags.inv   = (opa_i.zero & opb_i.inf) | (opb_i.zero & opa_i.inf);
    // any infinite input
    flags.inf   = opa_i.inf | opb_i.inf;
    flags.nan   = nan_i;
    // any zero input forces a zero product
    flags.opc_0 = opa_i.zero | opb_i.zero;
    flags.signc = opa_i.sign ^ opb_i.sign;
  end

  // denormals need pre-normalization
  fpu_mul_lzc lzc_a_inst (
    .fract_i (opa_i.fract24),
    .nlz_o   (nlza)
  );

  fpu_mul_lzc lzc_b_inst (
    .fract_i (opb_i.fract24),
    .nlz_o   (nlzb)
  );

  //////////////////////////////////////////////////////////////////////
  // stage 0 register
  //////////////////////////////////////////////////////////////////////

  // payload, frozen while adv_i is low
  always_ff @(posedge clk) begin
    if (adv_i) begin
      s0_o.flags    <= flags;
      s0_o.exp10a   <= opa_i.exp10;
      s0_o.exp10b   <= opb_i.exp10;
      s0_o.fract24a <= opa_i.fract24;
      s0_o.fract24b <= opb_i.fract24;
      s0_o.nlza     <= nlza;
      s0_o.nlzb     <= nlzb;
    end
  end

  // head of the ready chain
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rdy_o <= 1'b0;
    end else if (flush_i) begin
      rdy_o <= 1'b0;
    end else if (adv_i) begin
      rdy_o <= start_i;
    end
  end

endmodule

//--- hdl/fpu_mul_lzc.sv
// purely combinational; an all-zero fraction reports 0, callers must flag zero separately
`include "fpu_mul_settings.svh"

module fpu_mul_lzc (
  input  logic [`FPU_FRACT_W-1:0] fract_i,
  output logic [`FPU_SHR_W-1:0]   nlz_o
);

  //////////////////////////////////////////////////////////////////////
  // priority encoder
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    // default covers the zero fraction
    nlz_o = '0;
    // scan up from the lsb
    // highest set bit is written last and wins
    for (int i = 0; i < `FPU_FRACT_W; i++) begin
      if (fract_i[i]) begin
        nlz_o = `FPU_SHR_W'(`FPU_FRACT_W - 1 - i);
      end
    end
  end

endmodule

//--- hdl/fpu_mul_pkg.sv
// struct fields are msb first; widths come from the settings header, shared with the testbench
`include "fpu_mul_settings.svh"

package fpu_mul_pkg;

  // one unpacked operand, hidden bit already restored
  typedef struct packed {
    logic                    sign;
    logic [`FPU_EXP_W-1:0]   exp10;
    logic [`FPU_FRACT_W-1:0] fract24;
    logic                    inf;
    logic                    zero;
  } fpu_operand_t;

  // nan info decoded upstream, carried unchanged
  typedef struct packed {
    logic snan;
    logic qnan;
    logic anan_sign;
  } fpu_nan_t;

  // exception flags travelling down the pipe
  typedef struct packed {
    logic     inv;
    logic     inf;
    fpu_nan_t nan;
    // force result to zero
    logic     opc_0;
    logic     signc;
  } fpu_flags_t;

  // stage 0 register
  typedef struct packed {
    fpu_flags_t              flags;
    logic [`FPU_EXP_W-1:0]   exp10a;
    logic [`FPU_EXP_W-1:0]   exp10b;
    logic [`FPU_FRACT_W-1:0] fract24a;
    logic [`FPU_FRACT_W-1:0] fract24b;
    logic [`FPU_SHR_W-1:0]   nlza;
    logic [`FPU_SHR_W-1:0]   nlzb;
  } fpu_prenorm_t;

  // stage 2 register, alongside the partial products
  typedef struct packed {
    fpu_flags_t            flags;
    logic [`FPU_EXP_W-1:0] exp10c;
    logic [`FPU_SHR_W-1:0] shrx;
    logic [`FPU_EXP_W-1:0] exp10rx;
  } fpu_align_t;

  // output bundle for the align and round stage
  typedef struct packed {
    logic                        sign;
    logic [`FPU_SHR_W-1:0]       shr;
    logic [`FPU_EXP_W-1:0]       exp10shr;
    logic [`FPU_EXP_W-1:0]       exp10sh0;
    logic [`FPU_RES_FRACT_W-1:0] fract28;
    logic                        inv;
    logic                        inf;
    logic                        snan;
    logic                        qnan;
    logic                        anan_sign;
  } fpu_mul_res_t;

endpackage

//--- hdl/fpu_mul_settings.svh
// widths assume single precision; exponent kept 10 bits wide so negative sums stay visible
`ifndef FPU_MUL_SETTINGS_SVH
`define FPU_MUL_SETTINGS_SVH

//////////////////////////////////////////////////////////////////////
// operand and result widths
//////////////////////////////////////////////////////////////////////

// extended biased exponent, bit 9 flags a negative sum
`define FPU_EXP_W 10
// fraction including the hidden bit
`define FPU_FRACT_W 24
// right-shift amount for the align stage
`define FPU_SHR_W 5
// half of a 32-bit multiplier input
`define FPU_PART_W 16
// 26 fraction bits plus round and sticky
`define FPU_RES_FRACT_W 28

// single precision bias
`define FPU_BIAS 127
// advancing edges from start to ready
`define FPU_MUL_LATENCY 4

`endif
